/* rtl/rd_lane_align.sv */
////////////////////////////////////////////////////////////////////////////
// Read side of one port: spreads the address over the banks and puts the
// returned words back in address order. Reads wrap at the top of memory.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rd_lane_align
   import regfile_pkg::*;
#(
   parameter int NUM_LANES = 4
)
(
   input  logic                        clk,
   input  logic                        rst_n,

   input  addr_t                       rd_addr,
   output row_t [NUM_BANKS-1:0]        bank_row,

   input  word_t [NUM_BANKS-1:0]       bank_data,
   output word_t [NUM_LANES-1:0]       rd_data
);

   // bank offset of the read in flight
   bank_sel_t rd_ofs;

   // word rd_addr+k lives in bank (rd_addr+k) mod 4;
   // banks not needed by this port just read the base row
   always_comb
   begin
      addr_t lane_addr;

      lane_addr = rd_addr;
      for (int b = 0; b < NUM_BANKS; b++)
      begin
         bank_row[b] = rd_addr[ADDR_W-1:BANK_SEL_W];
      end
      for (int k = 0; k < NUM_LANES; k++)
      begin
         lane_addr = rd_addr + addr_t'(k);
         bank_row[lane_addr[BANK_SEL_W-1:0]] = lane_addr[ADDR_W-1:BANK_SEL_W];
      end
   end

   // sampled on the same edge as the bank read
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rd_ofs <= '0;
      end
      else
      begin
         rd_ofs <= rd_addr[BANK_SEL_W-1:0];
      end
   end

   // rotate bank words so that lane 0 holds word rd_addr
   always_comb
   begin
      bank_sel_t src_bank;

      src_bank = rd_ofs;
      for (int k = 0; k < NUM_LANES; k++)
      begin
         src_bank   = bank_sel_t'(rd_ofs + k);
         rd_data[k] = bank_data[src_bank];
      end
   end

endmodule

`default_nettype wire

/* rtl/regfile_512x32_top.sv */
////////////////////////////////////////////////////////////////////////////
// 512x32 register file with a 4-word and a 2-word read port and a
// 4-word and a 2-word write port. Reads have one cycle of latency and
// accept any alignment; writes must be aligned to their word count.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module regfile_512x32_top
   import regfile_pkg::*;
(
   input  logic                           clk,
   input  logic                           rst_n,

   input  addr_t                          wr0_addr,
   input  logic [NUM_BANKS-1:0]           wr0_en,
   input  logic [$bits(rd0_data_t)-1:0]   wr0_data,

   input  addr_t                          wr1_addr,
   input  logic [1:0]                     wr1_en,
   input  logic [$bits(rd1_data_t)-1:0]   wr1_data,

   input  addr_t                          rd0_addr,
   output rd0_data_t                      rd0_data,

   input  addr_t                          rd1_addr,
   output rd1_data_t                      rd1_data
);

   localparam int WIDE_LANES   = $bits(rd0_data_t) / WORD_W;
   localparam int NARROW_LANES = $bits(rd1_data_t) / WORD_W;

   logic  [NUM_BANKS-1:0] wr0_bank_en;
   word_t [NUM_BANKS-1:0] wr0_bank_data;
   row_t                  wr0_bank_row;

   logic  [NUM_BANKS-1:0] wr1_bank_en;
   word_t [NUM_BANKS-1:0] wr1_bank_data;
   row_t                  wr1_bank_row;

   row_t  [NUM_BANKS-1:0] rd0_bank_row;
   word_t [NUM_BANKS-1:0] rd0_bank_data;

   row_t  [NUM_BANKS-1:0] rd1_bank_row;
   word_t [NUM_BANKS-1:0] rd1_bank_data;

   wr_lane_steer #(.NUM_LANES(WIDE_LANES)) i_wr0_steer (
      .wr_addr   (wr0_addr),
      .wr_en     (wr0_en),
      .wr_data   (wr0_data),
      .bank_en   (wr0_bank_en),
      .bank_data (wr0_bank_data),
      .bank_row  (wr0_bank_row)
   );

   wr_lane_steer #(.NUM_LANES(NARROW_LANES)) i_wr1_steer (
      .wr_addr   (wr1_addr),
      .wr_en     (wr1_en),
      .wr_data   (wr1_data),
      .bank_en   (wr1_bank_en),
      .bank_data (wr1_bank_data),
      .bank_row  (wr1_bank_row)
   );

   rd_lane_align #(.NUM_LANES(WIDE_LANES)) i_rd0_align (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_addr   (rd0_addr),
      .bank_row  (rd0_bank_row),
      .bank_data (rd0_bank_data),
      .rd_data   (rd0_data)
   );

   rd_lane_align #(.NUM_LANES(NARROW_LANES)) i_rd1_align (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_addr   (rd1_addr),
      .bank_row  (rd1_bank_row),
      .bank_data (rd1_bank_data),
      .rd_data   (rd1_data)
   );

   // bank b holds every word whose address is b mod 4
   for (genvar b = 0; b < NUM_BANKS; b++)
   begin : g_bank
      regfile_bank i_bank (
         .clk      (clk),
         .wr0_en   (wr0_bank_en[b]),
         .wr0_row  (wr0_bank_row),
         .wr0_data (wr0_bank_data[b]),
         .wr1_en   (wr1_bank_en[b]),
         .wr1_row  (wr1_bank_row),
         .wr1_data (wr1_bank_data[b]),
         .rd0_row  (rd0_bank_row[b]),
         .rd0_data (rd0_bank_data[b]),
         .rd1_row  (rd1_bank_row[b]),
         .rd1_data (rd1_bank_data[b])
      );
   end

endmodule

`default_nettype wire

/* rtl/regfile_bank.sv */
////////////////////////////////////////////////////////////////////////////
// One 128-row bank of the register file. Two write ports and two read
// ports with one cycle of read latency; the top builds four of these.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module regfile_bank
   import regfile_pkg::*;
(
   input  logic  clk,

   input  logic  wr0_en,
   input  row_t  wr0_row,
   input  word_t wr0_data,

   input  logic  wr1_en,
   input  row_t  wr1_row,
   input  word_t wr1_data,

   input  row_t  rd0_row,
   output word_t rd0_data,

   input  row_t  rd1_row,
   output word_t rd1_data
);

   word_t mem [0:(1 << ROW_W)-1];

   // wr1 comes last so it wins when both ports hit the same row
   always_ff @(posedge clk)
   begin
      if (wr0_en)
      begin
         mem[wr0_row] <= wr0_data;
      end
      if (wr1_en)
      begin
         mem[wr1_row] <= wr1_data;
      end
   end

   // reads see the contents from before this edge's writes
   always_ff @(posedge clk)
   begin
      rd0_data <= mem[rd0_row];
      rd1_data <= mem[rd1_row];
   end

endmodule

`default_nettype wire

/* rtl/regfile_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared geometry and types for the banked 512x32 register file.
// Modules pull these in with a wildcard import in their headers.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package regfile_pkg;

   // one stored word
   parameter int WORD_W = 32;

   // word address bits 1:0 pick the bank, the rest pick the row
   parameter int NUM_BANKS  = 4;
   parameter int BANK_SEL_W = 2;
   parameter int ROW_W      = 7;
   parameter int ADDR_W     = ROW_W + BANK_SEL_W;

   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [ROW_W-1:0]      row_t;
   typedef logic [BANK_SEL_W-1:0] bank_sel_t;

   // wide read port, word at the requested address in lane 0
   typedef logic [NUM_BANKS*WORD_W-1:0] rd0_data_t;

   // narrow read port, two words
   typedef logic [2*WORD_W-1:0] rd1_data_t;

endpackage

`default_nettype wire

/* rtl/wr_lane_steer.sv */
////////////////////////////////////////////////////////////////////////////
// Steers one write port onto the four banks. Combinational only.
// NUM_LANES is 4 for the wide port and 2 for the narrow one.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module wr_lane_steer
   import regfile_pkg::*;
#(
   parameter int NUM_LANES = 4
)
(
   input  addr_t                               wr_addr,
   input  logic [NUM_LANES-1:0]                wr_en,
   input  logic [NUM_LANES-1:0][WORD_W-1:0]    wr_data,

   output logic [NUM_BANKS-1:0]                bank_en,
   output word_t [NUM_BANKS-1:0]               bank_data,
   output row_t                                bank_row
);

   logic legal;

   // legal requests are 1, 2 or 4 words starting at lane 0,
   // with the address aligned to the word count
   always_comb
   begin
      legal = (wr_en == '0);
      for (int c = 1; c <= NUM_LANES; c = c * 2)
      begin
         if ((wr_en == NUM_LANES'((1 << c) - 1)) &&
             ((wr_addr[BANK_SEL_W-1:0] & BANK_SEL_W'(c - 1)) == '0))
         begin
            legal = 1'b1;
         end
      end
   end

   // aligned requests never cross a row, so one row serves all banks
   assign bank_row = wr_addr[ADDR_W-1:BANK_SEL_W];

   always_comb
   begin
      bank_sel_t lane_bank;

      bank_en   = '0;
      bank_data = '0;
      lane_bank = '0;
      if (legal)
      begin
         for (int k = 0; k < NUM_LANES; k++)
         begin
            lane_bank = bank_sel_t'(wr_addr[BANK_SEL_W-1:0] + k);
            if (wr_en[k])
            begin
               bank_en[lane_bank]   = 1'b1;
               bank_data[lane_bank] = wr_data[k];
            end
         end
      end
   end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Compiles the register file testbench with Verilator and runs it.
# Exits nonzero unless the log holds the pass line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
   --top-module tb_regfile \
   -f tb.f \
   -o sim_regfile

# the pipe keeps going on a failing run so that the log is searched below
./obj_dir/sim_regfile | tee sim.log

if grep -qx "All checks passed" sim.log; then
   echo "simulation PASSED"
else
   echo "simulation FAILED"
   exit 1
fi

/* tb.f */
rtl/regfile_pkg.sv
rtl/regfile_bank.sv
rtl/wr_lane_steer.sv
rtl/rd_lane_align.sv
rtl/regfile_512x32_top.sv
tb/regfile_sva.sv
tb/tb_regfile.sv

/* tb/regfile_sva.sv */
////////////////////////////////////////////////////////////////////////////
// Write-port checks for the register file: legal enable patterns, address
// alignment, and no word written by both ports in one cycle. Bound to top.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module regfile_sva
   import regfile_pkg::*;
(
   input logic                 clk,
   input logic                 rst_n,
   input addr_t                wr0_addr,
   input logic [NUM_BANKS-1:0] wr0_en,
   input addr_t                wr1_addr,
   input logic [1:0]           wr1_en
);

   // one past the last word each port writes
   logic [ADDR_W:0] wr0_end;
   logic [ADDR_W:0] wr1_end;
   logic            overlap;

   assign wr0_end = {1'b0, wr0_addr} + (ADDR_W+1)'($countones(wr0_en));
   assign wr1_end = {1'b0, wr1_addr} + (ADDR_W+1)'($countones(wr1_en));
   assign overlap = (wr0_en != '0) && (wr1_en != '0) &&
                    ({1'b0, wr0_addr} < wr1_end) && ({1'b0, wr1_addr} < wr0_end);

   a_wr0_pattern : assert property (@(posedge clk) disable iff (!rst_n)
      wr0_en inside {4'b0000, 4'b0001, 4'b0011, 4'b1111})
      else $error("wr0 enable pattern %b is not legal", wr0_en);

   a_wr0_pair_align : assert property (@(posedge clk) disable iff (!rst_n)
      (wr0_en == 4'b0011) |-> (wr0_addr[0] == 1'b0))
      else $error("wr0 two-word write at odd address %h", wr0_addr);

   a_wr0_quad_align : assert property (@(posedge clk) disable iff (!rst_n)
      (wr0_en == 4'b1111) |-> (wr0_addr[1:0] == 2'b00))
      else $error("wr0 four-word write at unaligned address %h", wr0_addr);

   a_wr1_pattern : assert property (@(posedge clk) disable iff (!rst_n)
      wr1_en != 2'b10)
      else $error("wr1 enable pattern %b is not legal", wr1_en);

   a_wr1_pair_align : assert property (@(posedge clk) disable iff (!rst_n)
      (wr1_en == 2'b11) |-> (wr1_addr[0] == 1'b0))
      else $error("wr1 two-word write at odd address %h", wr1_addr);

   a_no_collision : assert property (@(posedge clk) disable iff (!rst_n) !overlap)
      else $error("wr0 at %h and wr1 at %h write the same word", wr0_addr, wr1_addr);

endmodule

bind regfile_512x32_top regfile_sva i_sva (
   .clk      (clk),
   .rst_n    (rst_n),
   .wr0_addr (wr0_addr),
   .wr0_en   (wr0_en),
   .wr1_addr (wr1_addr),
   .wr1_en   (wr1_en)
);

`default_nettype wire

/* tb/tb_regfile.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the 512x32 register file. Applies a stimulus table and
// then random traffic, and checks both read ports against a reference.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_regfile
   import regfile_pkg::*;
();

   localparam int RAND_COUNT = 200;

   typedef struct packed {
      logic [NUM_BANKS-1:0] wr0_en;
      addr_t                wr0_addr;
      rd0_data_t            wr0_data;
      logic [1:0]           wr1_en;
      addr_t                wr1_addr;
      rd1_data_t            wr1_data;
      addr_t                rd0_addr;
      addr_t                rd1_addr;
      logic                 check;
      logic                 quiet;
   } entry_t;

   logic                 clk = 1'b0;
   logic                 rst_n;
   addr_t                wr0_addr;
   logic [NUM_BANKS-1:0] wr0_en;
   rd0_data_t            wr0_data;
   addr_t                wr1_addr;
   logic [1:0]           wr1_en;
   rd1_data_t            wr1_data;
   addr_t                rd0_addr;
   rd0_data_t            rd0_data;
   addr_t                rd1_addr;
   rd1_data_t            rd1_data;

   word_t     ref_mem [0:(1 << ADDR_W)-1];
   entry_t    stim_q [$];
   integer    seed = 32'ha04d_f03e;
   int        cycle_cnt = 0;
   int        cycle_limit = 0;
   logic      sva_quiet = 1'b0;
   logic      pend_check = 1'b0;
   addr_t     pend_rd0_addr;
   addr_t     pend_rd1_addr;
   rd0_data_t pend_rd0;
   rd1_data_t pend_rd1;

   regfile_512x32_top i_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr0_addr (wr0_addr),
      .wr0_en   (wr0_en),
      .wr0_data (wr0_data),
      .wr1_addr (wr1_addr),
      .wr1_en   (wr1_en),
      .wr1_data (wr1_data),
      .rd0_addr (rd0_addr),
      .rd0_data (rd0_data),
      .rd1_addr (rd1_addr),
      .rd1_data (rd1_data)
   );

   always #4 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
      begin
         $display("ERROR: run timed out after %0d cycles", cycle_cnt);
         $display("Checks failed");
         $fatal(1, "timeout");
      end
   end

   // every bit of the address shows up in the word
   function automatic word_t fill_word(input addr_t a);
      return {7'h2a, a, 7'h15, ~a};
   endfunction

   // legal: one word anywhere, two at an even address, four at a multiple of four
   function automatic bit write_ok(input logic [3:0] en, input addr_t addr, input int lanes);
      case (en)
         4'b0001: return 1'b1;
         4'b0011: return addr[0] == 1'b0;
         4'b1111: return (lanes == 4) && (addr[1:0] == 2'b00);
         default: return 1'b0;
      endcase
   endfunction

   function automatic void store_write(input logic [3:0] en, input addr_t addr,
                                       input rd0_data_t data, input int lanes);
      if (write_ok(en, addr, lanes))
      begin
         for (int k = 0; k < lanes; k++)
         begin
            if (en[k])
            begin
               ref_mem[addr + addr_t'(k)] = data[k*WORD_W +: WORD_W];
            end
         end
      end
   endfunction

   function automatic rd0_data_t predict_rd0(input addr_t a);
      rd0_data_t r;

      for (int k = 0; k < 4; k++)
      begin
         r[k*WORD_W +: WORD_W] = ref_mem[a + addr_t'(k)];
      end
      return r;
   endfunction

   function automatic rd1_data_t predict_rd1(input addr_t a);
      return {ref_mem[a + addr_t'(1)], ref_mem[a]};
   endfunction

   function automatic void push_entry(input logic [3:0] w0_en, input addr_t w0_addr,
                                      input rd0_data_t w0_data, input logic [1:0] w1_en,
                                      input addr_t w1_addr, input rd1_data_t w1_data,
                                      input addr_t r0, input addr_t r1,
                                      input logic chk, input logic quiet);
      stim_q.push_back({w0_en, w0_addr, w0_data, w1_en, w1_addr, w1_data, r0, r1, chk, quiet});
   endfunction

   function automatic void push_read(input addr_t r0, input addr_t r1);
      push_entry(4'b0000, 9'h000, '0, 2'b00, 9'h000, '0, r0, r1, 1'b1, 1'b0);
   endfunction

   function automatic entry_t random_entry();
      entry_t     e;
      logic [3:0] pick;
      int         n0;
      int         n1;

      e = '0;
      pick = 4'($random(seed));
      case (pick[1:0])
         2'd0:    e.wr0_en = 4'b0000;
         2'd1:    e.wr0_en = 4'b0001;
         2'd2:    e.wr0_en = 4'b0011;
         default: e.wr0_en = 4'b1111;
      endcase
      e.wr1_en = (pick[3:2] == 2'd0) ? 2'b00 : ((pick[3:2] == 2'd1) ? 2'b01 : 2'b11);
      e.wr0_addr = addr_t'($random(seed));
      e.wr1_addr = addr_t'($random(seed));
      if (e.wr0_en == 4'b1111)
      begin
         e.wr0_addr[1:0] = 2'b00;
      end
      if (e.wr0_en == 4'b0011)
      begin
         e.wr0_addr[0] = 1'b0;
      end
      if (e.wr1_en == 2'b11)
      begin
         e.wr1_addr[0] = 1'b0;
      end
      e.wr0_data = {$random(seed), $random(seed), $random(seed), $random(seed)};
      e.wr1_data = {$random(seed), $random(seed)};
      e.rd0_addr = addr_t'($random(seed));
      e.rd1_addr = addr_t'($random(seed));
      // wr1 stays off the words that wr0 writes in this cycle
      n0 = $countones(e.wr0_en);
      n1 = $countones(e.wr1_en);
      if (n0 > 0 && n1 > 0 && int'(e.wr1_addr) < int'(e.wr0_addr) + n0 &&
          int'(e.wr0_addr) < int'(e.wr1_addr) + n1)
      begin
         e.wr1_en = 2'b00;
      end
      e.check = 1'b1;
      return e;
   endfunction

   task automatic check_rd0(input addr_t addr, input rd0_data_t got, input rd0_data_t exp);
      if (got !== exp)
      begin
         $display("MISMATCH rd0_data at rd0_addr %h: got %h, expected %h", addr, got, exp);
         $display("Checks failed");
         $fatal(1, "read port 0 returned a wrong value");
      end
   endtask

   task automatic check_rd1(input addr_t addr, input rd1_data_t got, input rd1_data_t exp);
      if (got !== exp)
      begin
         $display("MISMATCH rd1_data at rd1_addr %h: got %h, expected %h", addr, got, exp);
         $display("Checks failed");
         $fatal(1, "read port 1 returned a wrong value");
      end
   endtask

   // check the read issued one entry back, then drive the next entry
   task automatic apply_entry(input entry_t e);
      @(posedge clk);
      #1;
      if (pend_check)
      begin
         check_rd0(pend_rd0_addr, rd0_data, pend_rd0);
         check_rd1(pend_rd1_addr, rd1_data, pend_rd1);
      end
      if (e.quiet && !sva_quiet)
      begin
         $assertoff;
         sva_quiet = 1'b1;
      end
      else if (!e.quiet && sva_quiet)
      begin
         $asserton;
         sva_quiet = 1'b0;
      end
      wr0_en   = e.wr0_en;
      wr0_addr = e.wr0_addr;
      wr0_data = e.wr0_data;
      wr1_en   = e.wr1_en;
      wr1_addr = e.wr1_addr;
      wr1_data = e.wr1_data;
      rd0_addr = e.rd0_addr;
      rd1_addr = e.rd1_addr;
      // reads sampled with a write see the old contents
      pend_check    = e.check;
      pend_rd0_addr = e.rd0_addr;
      pend_rd1_addr = e.rd1_addr;
      pend_rd0      = predict_rd0(e.rd0_addr);
      pend_rd1      = predict_rd1(e.rd1_addr);
      store_write(e.wr0_en, e.wr0_addr, e.wr0_data, 4);
      store_write({2'b00, e.wr1_en}, e.wr1_addr, {64'h0, e.wr1_data}, 2);
   endtask

   initial
   begin
      rst_n    = 1'b0;
      wr0_en   = '0;
      wr0_addr = '0;
      wr0_data = '0;
      wr1_en   = '0;
      wr1_addr = '0;
      wr1_data = '0;
      rd0_addr = '0;
      rd1_addr = '0;

      // fill every word, then read it all back through both ports
      for (int a = 0; a < 512; a++)
      begin
         push_entry(4'b0001, addr_t'(a), {96'h0, fill_word(addr_t'(a))}, 2'b00, 9'h000, '0,
                    9'h000, 9'h000, 1'b0, 1'b0);
      end
      for (int a = 0; a < 512; a++)
      begin
         push_read(addr_t'(a), addr_t'(a));
      end

      // unaligned reads and wraparound at the top
      push_read(9'h005, 9'h009);
      push_read(9'h006, 9'h0ff);
      push_read(9'h007, 9'h1ff);
      push_read(9'h1fe, 9'h1ff);
      push_read(9'h1ff, 9'h001);

      // wide writes
      push_entry(4'b1111, 9'h040, {32'hd4d4_0003, 32'hd4d4_0002, 32'hd4d4_0001, 32'hd4d4_0000},
                 2'b00, 9'h000, '0, 9'h000, 9'h000, 1'b0, 1'b0);
      push_entry(4'b0011, 9'h082, {64'h0, 32'hd2d2_0001, 32'hd2d2_0000},
                 2'b11, 9'h104, {32'he2e2_0001, 32'he2e2_0000}, 9'h000, 9'h000, 1'b0, 1'b0);
      push_read(9'h040, 9'h042);
      push_read(9'h081, 9'h082);
      push_read(9'h103, 9'h104);

      // illegal requests leave memory alone
      push_entry(4'b0011, 9'h021, {64'h0, {2{32'hdead_0021}}}, 2'b00, 9'h000, '0,
                 9'h000, 9'h000, 1'b0, 1'b1);
      push_entry(4'b1111, 9'h022, {4{32'hdead_0022}}, 2'b10, 9'h030, {2{32'hdead_0030}},
                 9'h000, 9'h000, 1'b0, 1'b1);
      push_entry(4'b0101, 9'h050, {4{32'hdead_0050}}, 2'b11, 9'h031, {2{32'hdead_0031}},
                 9'h000, 9'h000, 1'b0, 1'b1);
      push_read(9'h020, 9'h024);
      push_read(9'h04f, 9'h052);
      push_read(9'h02f, 9'h031);

      // read during write, then the new value on the next read
      push_entry(4'b0001, 9'h060, {96'h0, 32'hbeef_0060}, 2'b01, 9'h063, {32'h0, 32'hbeef_0063},
                 9'h060, 9'h062, 1'b1, 1'b0);
      push_read(9'h060, 9'h062);

      // both write ports land in the same cycle on different banks
      push_entry(4'b0001, 9'h070, {96'h0, 32'hcafe_0070}, 2'b01, 9'h071, {32'h0, 32'hcafe_0071},
                 9'h000, 9'h000, 1'b0, 1'b0);
      push_entry(4'b0011, 9'h080, {64'h0, 32'hcafe_0081, 32'hcafe_0080},
                 2'b11, 9'h082, {32'hcafe_0083, 32'hcafe_0082}, 9'h000, 9'h000, 1'b0, 1'b0);
      push_read(9'h070, 9'h071);
      push_read(9'h080, 9'h082);

      cycle_limit = 2 * stim_q.size() + RAND_COUNT + 50;

      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;

      foreach (stim_q[i])
      begin
         apply_entry(stim_q[i]);
      end
      for (int i = 0; i < RAND_COUNT; i++)
      begin
         apply_entry(random_entry());
      end

      @(posedge clk);
      #1;
      if (pend_check)
      begin
         check_rd0(pend_rd0_addr, rd0_data, pend_rd0);
         check_rd1(pend_rd1_addr, rd1_data, pend_rd1);
      end

      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire
